// ==== rtl/addr_map_pkg.sv ====
// address map package: word width, address width and the three mapped ranges

`default_nettype none

package addr_map_pkg;

    // ----------------------------------------------------------------------
    // bus widths
    // ----------------------------------------------------------------------

    // the system address covers 64 word locations
    localparam int addr_width = 6;

    // every RAM carries the same word
    localparam int data_width = 16;

    // ----------------------------------------------------------------------
    // mapped ranges
    // ----------------------------------------------------------------------

    // ranges A, B and C, in that order, in every hit vector
    localparam int range_count = 3;

    // range A covers addresses 3 to 7 and uses an 8-word RAM
    localparam int range_a_base        = 3;
    localparam int range_a_count       = 5;
    localparam int range_a_index_width = 3;

    // range B covers addresses 10 to 21 and uses a 16-word RAM
    localparam int range_b_base        = 10;
    localparam int range_b_count       = 12;
    localparam int range_b_index_width = 4;

    // range C covers addresses 40 to 46 and uses an 8-word RAM
    localparam int range_c_base        = 40;
    localparam int range_c_count       = 7;
    localparam int range_c_index_width = 3;

    // addresses outside all three ranges are unmapped and raise an error

endpackage

`default_nettype wire

// ==== rtl/address_range_decoder.sv ====
// range decoder: raises hit while the address lies inside one mapped range

`timescale 1ns/10ps
`default_nettype none

module address_range_decoder
    import addr_map_pkg::*;
#(
    parameter int range_base  = 0,
    parameter int range_count = 1
) (
    input  wire logic [addr_width-1:0] address,
    output logic                       hit
);

    // ----------------------------------------------------------------------
    // range bounds
    // ----------------------------------------------------------------------

    // both bounds are inclusive, so the last word sits at base plus count minus one
    localparam int lower_bound = range_base;
    localparam int upper_bound = range_base + range_count - 1;

    // the address is widened to int so the compare cannot wrap
    int address_value;

    // ----------------------------------------------------------------------
    // compare
    // ----------------------------------------------------------------------

    // the bounds are constants, so this folds into a small fixed function
    // of the six address bits
    always_comb begin
        address_value = int'(address);
        hit = (address_value >= lower_bound) && (address_value <= upper_bound);
    end

endmodule

`default_nettype wire

// ==== rtl/address_range_translator.sv ====
// range translator: maps the rotated low address bits of a range to a zero-based index

`timescale 1ns/10ps
`default_nettype none

module address_range_translator #(
    parameter int range_base  = 0,
    parameter int range_count = 1,
    parameter int index_width = 1
) (
    input  wire logic [index_width-1:0] raw_index,
    output logic      [index_width-1:0] translated_index
);

    // ----------------------------------------------------------------------
    // translation table
    // ----------------------------------------------------------------------

    // one entry per value of the low address bits
    localparam int table_depth = 2 ** index_width;

    typedef logic [index_width-1:0] index_t;
    typedef index_t [table_depth-1:0] table_t;

    // a range rarely starts on a power-of-two boundary, so its low bits
    // run through a rotated sequence, e.g. base 10 gives 10, 11, .. 15, 0, 1
    // entry (base + k) mod depth holds k, which undoes that rotation
    function automatic table_t build_table();
        table_t entries;
        int     slot;
        // unused slots hold zero so that every entry is defined
        entries = '0;
        slot = range_base % table_depth;
        for (int k = 0; k < range_count; k++) begin
            entries[slot] = index_t'(k);
            // wrap around at the top of the table
            slot = (slot + 1) % table_depth;
        end
        return entries;
    endfunction

    // evaluated at elaboration, so there is no storage behind it
    localparam table_t index_table = build_table();

    // ----------------------------------------------------------------------
    // lookup
    // ----------------------------------------------------------------------

    // for every address inside the range this equals address minus base;
    // a constant lookup like this reduces to rewiring and a little logic
    always_comb begin
        translated_index = index_table[raw_index];
    end

endmodule

`default_nettype wire

// ==== rtl/range_ram.sv ====
// range RAM: single-port word memory with synchronous write and registered read

`timescale 1ns/10ps
`default_nettype none

module range_ram
    import addr_map_pkg::*;
#(
    parameter int index_width = 1
) (
    input  wire logic                   clock,
    input  wire logic                   write_strobe,
    input  wire logic                   read_strobe,
    input  wire logic [index_width-1:0] index,
    input  wire logic [data_width-1:0]  write_data,
    output logic      [data_width-1:0]  read_word
);

    // ----------------------------------------------------------------------
    // storage
    // ----------------------------------------------------------------------

    // the RAM holds a full power of two words, even where the range is
    // shorter, and the translator only ever reaches the first count of them
    localparam int word_count = 2 ** index_width;

    logic [data_width-1:0] memory [word_count];

    // ----------------------------------------------------------------------
    // write and read ports
    // ----------------------------------------------------------------------

    // the top never raises both strobes in the same cycle
    always_ff @(posedge clock) begin
        if (write_strobe) begin
            memory[index] <= write_data;
        end
    end

    // read_word keeps the last word read until the next read strobe
    always_ff @(posedge clock) begin
        if (read_strobe) begin
            read_word <= memory[index];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/read_data_select.sv ====
// read data select: picks the hit RAM's word and registers the result and status pulses

`timescale 1ns/10ps
`default_nettype none

module read_data_select
    import addr_map_pkg::*;
(
    input  wire logic                   clock,
    input  wire logic                   arst_n,
    input  wire logic                   read,
    input  wire logic [range_count-1:0] hit,
    input  wire logic                   error,
    input  wire logic [data_width-1:0]  word_a,
    input  wire logic [data_width-1:0]  word_b,
    input  wire logic [data_width-1:0]  word_c,
    output logic                        read_valid,
    output logic      [data_width-1:0]  read_data,
    output logic                        access_error
);

    // ----------------------------------------------------------------------
    // word select
    // ----------------------------------------------------------------------

    logic [data_width-1:0] selected_word;
    logic                  read_hit;

    // hit is one-hot or zero, so an and-or mux is enough
    // bit 0 belongs to range A, bit 1 to B and bit 2 to C
    always_comb begin
        selected_word = ({data_width{hit[0]}} & word_a)
                      | ({data_width{hit[1]}} & word_b)
                      | ({data_width{hit[2]}} & word_c);
        // a read only counts if some range owned the address
        read_hit = read && (|hit);
    end

    // ----------------------------------------------------------------------
    // output register
    // ----------------------------------------------------------------------

    // read_valid and access_error are one-cycle pulses
    // read_data only moves on a valid read, otherwise it keeps the last word
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            read_valid   <= 1'b0;
            access_error <= 1'b0;
            read_data    <= '0;
        end else begin
            read_valid   <= read_hit;
            access_error <= error;
            if (read_hit) begin
                read_data <= selected_word;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mapped_memory_top.sv ====
// mapped memory top: three-stage pipeline over three word RAMs at unaligned ranges

`timescale 1ns/10ps
`default_nettype none

module mapped_memory_top
    import addr_map_pkg::*;
(
    input  wire logic                  clock,
    input  wire logic                  arst_n,
    input  wire logic                  access_strobe,
    input  wire logic                  write_enable,
    input  wire logic [addr_width-1:0] address,
    input  wire logic [data_width-1:0] write_data,
    output logic                       read_valid,
    output logic      [data_width-1:0] read_data,
    output logic                       access_error
);

    // ----------------------------------------------------------------------
    // stage 1, capture
    // ----------------------------------------------------------------------

    logic                  s1_strobe;
    logic                  s1_write;
    logic [addr_width-1:0] s1_address;
    logic [data_width-1:0] s1_write_data;

    // the strobe is the only control bit here, the rest is qualified by it
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            s1_strobe <= 1'b0;
        end else begin
            s1_strobe <= access_strobe;
        end
    end

    always_ff @(posedge clock) begin
        s1_write      <= write_enable;
        s1_address    <= address;
        s1_write_data <= write_data;
    end

    // ----------------------------------------------------------------------
    // stage 2, decode, translate and RAM access
    // ----------------------------------------------------------------------

    // bit 0 is range A, bit 1 range B, bit 2 range C
    logic [range_count-1:0] range_hit;
    logic                   s1_read_req;
    logic                   s1_write_req;

    logic [range_a_index_width-1:0] index_a;
    logic [range_b_index_width-1:0] index_b;
    logic [range_c_index_width-1:0] index_c;

    logic [data_width-1:0] word_a;
    logic [data_width-1:0] word_b;
    logic [data_width-1:0] word_c;

    always_comb begin
        s1_read_req  = s1_strobe && !s1_write;
        s1_write_req = s1_strobe && s1_write;
    end

    // range A
    address_range_decoder #(.range_base(range_a_base), .range_count(range_a_count)) decode_a (
        .address (s1_address),
        .hit     (range_hit[0])
    );

    address_range_translator #(
        .range_base  (range_a_base),
        .range_count (range_a_count),
        .index_width (range_a_index_width)
    ) translate_a (
        .raw_index        (s1_address[range_a_index_width-1:0]),
        .translated_index (index_a)
    );

    range_ram #(.index_width(range_a_index_width)) ram_a (
        .clock        (clock),
        .write_strobe (s1_write_req && range_hit[0]),
        .read_strobe  (s1_read_req && range_hit[0]),
        .index        (index_a),
        .write_data   (s1_write_data),
        .read_word    (word_a)
    );

    // range B
    address_range_decoder #(.range_base(range_b_base), .range_count(range_b_count)) decode_b (
        .address (s1_address),
        .hit     (range_hit[1])
    );

    address_range_translator #(
        .range_base  (range_b_base),
        .range_count (range_b_count),
        .index_width (range_b_index_width)
    ) translate_b (
        .raw_index        (s1_address[range_b_index_width-1:0]),
        .translated_index (index_b)
    );

    range_ram #(.index_width(range_b_index_width)) ram_b (
        .clock        (clock),
        .write_strobe (s1_write_req && range_hit[1]),
        .read_strobe  (s1_read_req && range_hit[1]),
        .index        (index_b),
        .write_data   (s1_write_data),
        .read_word    (word_b)
    );

    // range C
    address_range_decoder #(.range_base(range_c_base), .range_count(range_c_count)) decode_c (
        .address (s1_address),
        .hit     (range_hit[2])
    );

    address_range_translator #(
        .range_base  (range_c_base),
        .range_count (range_c_count),
        .index_width (range_c_index_width)
    ) translate_c (
        .raw_index        (s1_address[range_c_index_width-1:0]),
        .translated_index (index_c)
    );

    range_ram #(.index_width(range_c_index_width)) ram_c (
        .clock        (clock),
        .write_strobe (s1_write_req && range_hit[2]),
        .read_strobe  (s1_read_req && range_hit[2]),
        .index        (index_c),
        .write_data   (s1_write_data),
        .read_word    (word_c)
    );

    // control that travels beside the RAM read into stage 3
    logic                   s2_read;
    logic [range_count-1:0] s2_hit;
    logic                   s2_error;

    // an access that no range claims becomes an error, reads and writes alike
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            s2_read  <= 1'b0;
            s2_hit   <= '0;
            s2_error <= 1'b0;
        end else begin
            s2_read  <= s1_read_req;
            s2_hit   <= range_hit;
            s2_error <= s1_strobe && !(|range_hit);
        end
    end

    // ----------------------------------------------------------------------
    // stage 3, select
    // ----------------------------------------------------------------------

    read_data_select select_stage (
        .clock        (clock),
        .arst_n       (arst_n),
        .read         (s2_read),
        .hit          (s2_hit),
        .error        (s2_error),
        .word_a       (word_a),
        .word_b       (word_b),
        .word_c       (word_c),
        .read_valid   (read_valid),
        .read_data    (read_data),
        .access_error (access_error)
    );

endmodule

`default_nettype wire

// ==== verif/mapped_memory_tb.sv ====
// testbench that drives accesses over the whole address space of the mapped memory and checks every result

`timescale 1ns/10ps
`default_nettype none

module mapped_memory_tb
    import addr_map_pkg::*;
();

    // the longest run is about 1000 cycles, so this limit is twice that
    localparam int max_cycles   = 2000;
    localparam int address_span = 2 ** addr_width;

    logic                  clock = 1'b0;
    logic                  arst_n;
    logic                  access_strobe;
    logic                  write_enable;
    logic [addr_width-1:0] address;
    logic [data_width-1:0] write_data;
    logic                  read_valid;
    logic [data_width-1:0] read_data;
    logic                  access_error;

    integer seed = 32'hc670_c72b;
    int     cycle_count = 0;
    int     value_errors = 0;
    int     other_errors = 0;

    // model contents per range, indexed by address minus base
    logic [data_width-1:0] model_words [range_count][16];

    // expected results in issue order, with the cycle each one is due
    logic                  exp_error [$];
    logic [data_width-1:0] exp_data [$];
    int                    exp_due [$];

    // last word that a valid read returned, zero from reset until the first read
    logic [data_width-1:0] held_word = '0;

    mapped_memory_top DUT (
        .clock         (clock),
        .arst_n        (arst_n),
        .access_strobe (access_strobe),
        .write_enable  (write_enable),
        .address       (address),
        .write_data    (write_data),
        .read_valid    (read_valid),
        .read_data     (read_data),
        .access_error  (access_error)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    // ----------------------------------------------------------------------
    // reference model and helpers
    // ----------------------------------------------------------------------

    // returns the owning range (0 for A, 1 for B, 2 for C) or -1 when unmapped
    function automatic int lookup_range(input logic [addr_width-1:0] addr, output int index);
        int a;
        a = int'(addr);
        index = 0;
        lookup_range = -1;
        if (a >= range_a_base && a < range_a_base + range_a_count) begin
            lookup_range = 0;
            index = a - range_a_base;
        end else if (a >= range_b_base && a < range_b_base + range_b_count) begin
            lookup_range = 1;
            index = a - range_b_base;
        end else if (a >= range_c_base && a < range_c_base + range_c_count) begin
            lookup_range = 2;
            index = a - range_c_base;
        end
    endfunction

    task automatic draw_random(output logic [31:0] value);
        value = $random(seed);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] actual,
                                   input logic [31:0] expected);
        value_errors++;
        $display("error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
    endtask

    // a result leaves the select stage three edges after the drive edge
    task automatic expect_result(input logic is_error, input logic [data_width-1:0] word);
        exp_error.push_back(is_error);
        exp_data.push_back(word);
        exp_due.push_back(cycle_count + 3);
    endtask

    task automatic issue_access(input logic write, input logic [addr_width-1:0] addr,
                                input logic [data_width-1:0] data);
        int range_id;
        int index;
        @(posedge clock);
        #1;
        access_strobe = 1'b1;
        write_enable  = write;
        address       = addr;
        write_data    = data;
        range_id = lookup_range(addr, index);
        if (range_id < 0) begin
            expect_result(1'b1, '0);
        end else if (write) begin
            model_words[range_id][index] = data;
        end else begin
            expect_result(1'b0, model_words[range_id][index]);
        end
    endtask

    task automatic idle_cycle();
        @(posedge clock);
        #1;
        access_strobe = 1'b0;
        write_enable  = 1'b0;
    endtask

    task automatic read_all_mapped();
        int index;
        for (int a = 0; a < address_span; a++) begin
            if (lookup_range(addr_width'(a), index) >= 0) begin
                issue_access(1'b0, addr_width'(a), '0);
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // result checking
    // ----------------------------------------------------------------------

    // outputs change at the rising edge, so the falling edge sees them settled
    always @(negedge clock) begin : compare_results
        logic                  want_error;
        logic [data_width-1:0] want_word;
        int                    due;
        if (exp_due.size() != 0 && exp_due[0] < cycle_count) begin
            other_errors++;
            $display("at %0t an expected result never arrived", $time);
            void'(exp_error.pop_front());
            void'(exp_data.pop_front());
            void'(exp_due.pop_front());
        end
        if (read_valid || access_error) begin
            assert (exp_due.size() != 0) else begin
                other_errors++;
                $display("at %0t a result pulse arrived while none was expected", $time);
            end
            if (exp_due.size() != 0) begin
                want_error = exp_error.pop_front();
                want_word  = exp_data.pop_front();
                due        = exp_due.pop_front();
                assert (cycle_count == due) else
                    report_mismatch("result cycle", cycle_count, due);
                assert (access_error === want_error) else
                    report_mismatch("access_error", 32'(access_error), 32'(want_error));
                assert (read_valid === !want_error) else
                    report_mismatch("read_valid", 32'(read_valid), 32'(!want_error));
                // a valid read carries the model word, which read_data then holds
                if (!want_error) begin
                    assert (read_data === want_word) else
                        report_mismatch("read_data", 32'(read_data), 32'(want_word));
                    held_word = want_word;
                end
            end
        end
        // between valid reads read_data keeps the last word read
        if (!read_valid) begin
            assert (read_data === held_word) else
                report_mismatch("read_data", 32'(read_data), 32'(held_word));
        end
    end

    initial begin : watchdog
        while (cycle_count < max_cycles) begin
            @(posedge clock);
        end
        $display("timeout: the run did not end within %0d cycles", max_cycles);
        $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------

    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] d;
        int          index;
        arst_n        = 1'b0;
        access_strobe = 1'b0;
        write_enable  = 1'b0;
        address       = '0;
        write_data    = '0;
        repeat (3) @(posedge clock);
        #1;
        arst_n = 1'b1;

        // quiet outputs after reset
        repeat (2) @(posedge clock);
        @(negedge clock);
        assert (read_valid === 1'b0) else report_mismatch("read_valid", 32'(read_valid), 0);
        assert (access_error === 1'b0) else
            report_mismatch("access_error", 32'(access_error), 0);

        // fill every mapped word and put the address in its low bits so that all words differ
        for (int a = 0; a < address_span; a++) begin
            if (lookup_range(addr_width'(a), index) >= 0) begin
                draw_random(r);
                issue_access(1'b1, addr_width'(a), {r[data_width-1:addr_width], addr_width'(a)});
            end
        end
        read_all_mapped();

        // unmapped writes and reads must only raise errors
        for (int a = 0; a < address_span; a++) begin
            if (lookup_range(addr_width'(a), index) < 0) begin
                draw_random(r);
                issue_access(1'b1, addr_width'(a), r[data_width-1:0]);
                issue_access(1'b0, addr_width'(a), '0);
            end
        end
        read_all_mapped();

        // a read right behind a write to the same address sees the new word
        for (int a = 0; a < address_span; a += 3) begin
            draw_random(r);
            issue_access(1'b1, addr_width'(a), r[data_width-1:0]);
            issue_access(1'b0, addr_width'(a), '0);
        end

        // random traffic with gaps in the strobe
        for (int i = 0; i < 600; i++) begin
            draw_random(r);
            draw_random(d);
            if (r[1:0] == 2'b00) begin
                idle_cycle();
            end
            issue_access(r[2], r[8:3], d[data_width-1:0]);
        end

        idle_cycle();
        repeat (6) @(posedge clock);
        @(negedge clock);
        assert (exp_due.size() == 0) else begin
            other_errors++;
            $display("%0d expected results were still pending at the end", exp_due.size());
        end
        $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/addr_map_pkg.sv
rtl/address_range_decoder.sv
rtl/address_range_translator.sv
rtl/range_ram.sv
rtl/read_data_select.sv
rtl/mapped_memory_top.sv
verif/mapped_memory_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the mapped memory testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

log_file=sim.log
build_dir=obj_dir

# immediate assertions only run when --assert is given
verilator --binary --timing --assert \
    --timescale 1ns/10ps \
    --top-module mapped_memory_tb \
    -Mdir "$build_dir" \
    -f tb.f
if [ $? -ne 0 ]; then
    echo "run_sim: the Verilator build failed"
    exit 1
fi

"./$build_dir/Vmapped_memory_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "run_sim: the simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$log_file"; then
    echo "run_sim: the testbench reported a failure"
    exit 1
fi

echo "run_sim: no failure found in $log_file"
exit 0
